// ==== build.f ====
+incdir+source
source/runner_pkg.sv
source/uart_sampler.sv
source/command_decoder.sv
source/jump_physics.sv
source/obstacle_track.sv
source/scoreboard.sv
source/score_display.sv
source/runner_top.sv
dv/tb_clock.sv
dv/runner_chk.sv
dv/tb_runner.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the runner testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_runner -Mdir obj_dir -o sim_runner \
	&& ./obj_dir/sim_runner | tee /dev/stderr | grep -qx ">>> PASS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== dv/tb_runner.sv ====
`timescale 1ns/1ns
`include "runner_settings.svh"
`default_nettype none

module tb_runner;
	import runner_pkg::*;

	localparam int BIT_CLKS = `CLK_HZ / `BAUD;
	localparam int TICK = `GAME_TICK_CYCLES;
	localparam int GROUND = `GROUND_Y;
	// Rough length of each test in clocks
	localparam int LEN_T1 = 25 * TICK;
	localparam int LEN_T2 = 40 * TICK;
	localparam int LEN_T3 = 100 * TICK;
	localparam int LEN_T4 = 260 * TICK;
	localparam int LEN_T5 = 320 * TICK;
	localparam longint WATCHDOG_NS = 64'(LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5) * 2 * 100;

	logic  Clock;
	logic  rst_n;
	logic  rx;
	logic  crashed;
	ypos_t runner_y;
	xpos_t obstacle_x;
	seg_t  hex0, hex1, hex2, hex3, hex4, hex5;

	// Reference model state
	int m_x, m_y, m_vel, m_duck, m_prev_x, m_score, m_best, last_obs, gap;
	bit m_air, m_cr, m_cr_prev, first_tick, rst_seen;
	int errors, checks, min_y, target;
	ypos_t held_y;

	tb_clock #(.PERIOD_NS(100)) i_clock (.Clock(Clock));

	runner_top i_dut (
		.Clock(Clock), .rst_n(rst_n), .rx(rx), .crashed(crashed),
		.runner_y(runner_y), .obstacle_x(obstacle_x),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

	function automatic seg_t seg_of(input int d);
		case (d)
			0: return 7'h40;
			1: return 7'h79;
			2: return 7'h24;
			3: return 7'h30;
			4: return 7'h19;
			5: return 7'h12;
			6: return 7'h02;
			7: return 7'h78;
			8: return 7'h00;
			9: return 7'h10;
			default: return 7'h7f;
		endcase
	endfunction

	function automatic bit overlap_of(input int x, input int y);
		int dx;
		int dy;
		dx = (x > `RUNNER_X) ? x - `RUNNER_X : `RUNNER_X - x;
		dy = (y > `OBSTACLE_Y) ? y - `OBSTACLE_Y : `OBSTACLE_Y - y;
		return (dx <= `HIT_W) && (dy <= `HIT_H);
	endfunction

	// One game step of the reference model
	function automatic void step_reference();
		int ny;
		if (m_duck > 0)
			m_duck--;
		if (m_air) begin
			ny = m_y + m_vel;
			if (ny >= GROUND) begin
				m_y = GROUND;   // Snap to ground
				m_vel = 0;
				m_air = 0;
			end else begin
				m_y = ny;
				m_vel += `GRAVITY;
			end
		end
		m_x = (m_x <= 1) ? `SCREEN_W - `BOX_W : m_x - 1;
	endfunction

	function automatic void apply_command(input logic [7:0] b);
		if (b == "J" && !m_air && m_duck == 0 && !m_cr) begin
			m_vel = -`JUMP_FORCE;
			m_air = 1;
		end else if (b == "D" && !m_air && !m_cr)
			m_duck = `DUCK_STEPS;
	endfunction

	function automatic void count_error();
		errors++;
	endfunction

	always @(posedge Clock) rst_seen <= rst_n;

	// Comparing process on the falling edge where outputs are stable
	always @(negedge Clock) begin
		if (!rst_seen) begin
			m_x = `SCREEN_W;
			m_y = GROUND;
			m_vel = 0;
			m_air = 0;
			m_duck = 0;
			m_cr = 0;
			m_cr_prev = 0;
			m_prev_x = `SCREEN_W;
			m_score = 0;
			last_obs = `SCREEN_W;
			first_tick = 1;
			gap = 0;
		end else begin
			if (int'(obstacle_x) != last_obs) begin
				assert (!m_cr_prev) else begin
					count_error();
					$display("Obstacle moved although the game had crashed");
				end
				assert (first_tick || gap == TICK) else begin
					count_error();
					$display("Game step came after %0d clocks instead of %0d", gap, TICK);
				end
				step_reference();
				last_obs = obstacle_x;
				first_tick = 0;
				gap = 0;
			end
			gap++;
			checks++;
			assert (int'(obstacle_x) == m_x) else begin
				count_error();
				$display("FAILED obstacle_x: got %h expected %h", obstacle_x, m_x[8:0]);
			end
			assert (int'(runner_y) == m_y) else begin
				count_error();
				$display("FAILED runner_y: got %h expected %h", runner_y, m_y[7:0]);
			end
			assert (crashed == m_cr) else begin
				count_error();
				$display("FAILED crashed: got %h expected %h", crashed, m_cr);
			end
			assert ({hex2, hex1, hex0} == {seg_of(m_score / 100 % 10),
					seg_of(m_score / 10 % 10), seg_of(m_score % 10)}) else begin
				count_error();
				$display("FAILED hex2..hex0: got %h %h %h expected %h %h %h",
					hex2, hex1, hex0, seg_of(m_score / 100 % 10),
					seg_of(m_score / 10 % 10), seg_of(m_score % 10));
			end
			assert ({hex5, hex4, hex3} == {seg_of(m_best / 100 % 10),
					seg_of(m_best / 10 % 10), seg_of(m_best % 10)}) else begin
				count_error();
				$display("FAILED hex5..hex3: got %h %h %h expected %h %h %h",
					hex5, hex4, hex3, seg_of(m_best / 100 % 10),
					seg_of(m_best / 10 % 10), seg_of(m_best % 10));
			end
			// Scoreboard registers for the next edge
			if (m_x <= `RUNNER_X && m_prev_x > `RUNNER_X && !overlap_of(m_x, m_y) && !m_cr)
				m_score++;
			if (m_cr && !m_cr_prev && m_score > m_best)
				m_best = m_score;
			m_cr_prev = m_cr;
			m_cr = m_cr | overlap_of(m_x, m_y);
			m_prev_x = m_x;
		end
	end

	task automatic wait_ticks(input int n);
		xpos_t seen;
		int count;
		seen = obstacle_x;
		count = 0;
		while (count < n) begin
			@(negedge Clock);
			if (obstacle_x != seen) begin
				count++;
				seen = obstacle_x;
			end
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};   // Stop, data LSB first, start
		for (int i = 0; i < 10; i++) begin
			rx = frame[i];
			repeat (BIT_CLKS) @(negedge Clock);
		end
	endtask

	// Byte placed so its command lands mid game step
	task automatic issue_command(input logic [7:0] b);
		wait_ticks(1);
		repeat (20) @(negedge Clock);
		send_byte(b);
		repeat (10) @(negedge Clock);
		apply_command(b);
	endtask

	task automatic apply_reset();
		@(negedge Clock);
		rst_n = 1'b0;
		repeat (5) @(negedge Clock);
		rst_n = 1'b1;
	endtask

	task automatic wait_crash(input int limit);
		int n;
		n = 0;
		while (!crashed && n < limit) begin
			@(negedge Clock);
			n++;
		end
		assert (crashed) else begin
			count_error();
			$display("The game never crashed within %0d clocks", limit);
		end
	endtask

	initial begin
		int r;
		rst_n = 1'b0;
		rx = 1'b1;
		errors = 0;
		checks = 0;
		rst_seen = 0;
		m_best = 0;
		void'($urandom(20));
		apply_reset();

		// Scroll and idle display
		wait_ticks(20);

		// Plain jump with the obstacle far away
		issue_command("J");
		min_y = GROUND;
		for (int i = 0; i < 25; i++) begin
			wait_ticks(1);
			if (runner_y < min_y)
				min_y = runner_y;
		end
		assert (min_y == GROUND - 55) else begin
			count_error();
			$display("FAILED runner_y peak: got %h expected %h", min_y[7:0], 8'(GROUND - 55));
		end
		assert (runner_y == GROUND) else begin
			count_error();
			$display("FAILED runner_y after landing: got %h expected %h", runner_y,
				8'(GROUND));
		end

		// Bytes that must not move the runner
		issue_command("I");
		wait_ticks(2);
		for (int i = 0; i < 3; i++) begin
			r = $urandom & 8'hff;
			while (r == "J" || r == "D")
				r = $urandom & 8'hff;
			issue_command(r[7:0]);
			wait_ticks(2);
			assert (runner_y == GROUND) else begin
				count_error();
				$display("FAILED runner_y after byte %h: got %h expected %h", r[7:0],
					runner_y, 8'(GROUND));
			end
		end
		issue_command("D");
		issue_command("J");   // Blocked by the duck timer
		for (int i = 0; i < 25; i++) begin
			wait_ticks(1);
			assert (runner_y == GROUND) else begin
				count_error();
				$display("FAILED runner_y while ducking: got %h expected %h", runner_y,
					8'(GROUND));
			end
		end
		wait_ticks(`DUCK_STEPS);

		// Jump timed to be high when the obstacle reaches the hitbox
		target = `RUNNER_X + `HIT_W + 9;
		while (int'(obstacle_x) != target)
			@(negedge Clock);
		issue_command("J");
		wait_crash(60 * TICK);
		held_y = runner_y;
		repeat (3 * TICK) @(negedge Clock);
		assert (runner_y == held_y) else begin
			count_error();
			$display("FAILED runner_y after crash: got %h expected %h", runner_y, held_y);
		end
		apply_reset();

		// No jump, straight into the obstacle
		wait_crash(300 * TICK);
		repeat (3 * TICK) @(negedge Clock);
		apply_reset();
		repeat (2) @(negedge Clock);
		assert ({hex2, hex1, hex0} == {seg_of(0), seg_of(0), seg_of(0)}) else begin
			count_error();
			$display("FAILED hex2..hex0 after reset: got %h %h %h expected %h %h %h",
				hex2, hex1, hex0, seg_of(0), seg_of(0), seg_of(0));
		end
		repeat (10) @(negedge Clock);

		$display("Checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish in time, errors so far: %0d", errors);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/runner_chk.sv ====
`timescale 1ns/1ns
`include "runner_settings.svh"
`default_nettype none

module runner_chk (
	input logic       Clock,
	input logic       rst_n,
	input logic       crashed,
	input logic [7:0] runner_y,
	input logic [8:0] obstacle_x
);

	// Crash latch only clears through reset
	a_crash_held: assert property (@(posedge Clock)
		$fell(crashed) |-> !$past(rst_n))
		else $error("crashed fell without a reset");

	a_above_ground: assert property (@(posedge Clock) disable iff (!rst_n)
		runner_y <= 8'(`GROUND_Y))
		else $error("runner_y below the ground row");

	// Track frozen once the crash is registered
	a_frozen: assert property (@(posedge Clock) disable iff (!rst_n)
		($past(crashed) && $past(rst_n)) |-> $stable(obstacle_x))
		else $error("obstacle_x moved while crashed");

endmodule

bind runner_top runner_chk i_chk (
	.Clock      (Clock),
	.rst_n      (rst_n),
	.crashed    (crashed),
	.runner_y   (runner_y),
	.obstacle_x (obstacle_x)
);

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic Clock
);

	initial begin
		Clock = 1'b0;
		forever #(PERIOD_NS / 2) Clock = ~Clock;   // Free running
	end

endmodule

`default_nettype wire

// ==== source/runner_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module runner_top (
	input  logic              Clock,
	input  logic              rst_n,
	input  logic              rx,
	output logic              crashed,
	output runner_pkg::ypos_t runner_y,
	output runner_pkg::xpos_t obstacle_x,
	output runner_pkg::seg_t  hex0,
	output runner_pkg::seg_t  hex1,
	output runner_pkg::seg_t  hex2,
	output runner_pkg::seg_t  hex3,
	output runner_pkg::seg_t  hex4,
	output runner_pkg::seg_t  hex5
);
	import runner_pkg::*;

	logic [7:0] rx_byte;
	logic       rx_strobe;
	logic       jump_cmd;
	logic       duck_cmd;
	logic       game_tick;   // One pulse per game step
	score_t     score;
	score_t     high_score;

	uart_sampler i_uart_sampler (
		.Clock     (Clock),
		.rst_n     (rst_n),
		.rx        (rx),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe)
	);

	command_decoder i_command_decoder (
		.Clock     (Clock),
		.rst_n     (rst_n),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe),
		.jump_cmd  (jump_cmd),
		.duck_cmd  (duck_cmd)
	);

	jump_physics i_jump_physics (
		.Clock     (Clock),
		.rst_n     (rst_n),
		.game_tick (game_tick),
		.jump_cmd  (jump_cmd),
		.duck_cmd  (duck_cmd),
		.crashed   (crashed),
		.runner_y  (runner_y)
	);

	obstacle_track i_obstacle_track (
		.Clock      (Clock),
		.rst_n      (rst_n),
		.crashed    (crashed),
		.game_tick  (game_tick),
		.obstacle_x (obstacle_x)
	);

	scoreboard i_scoreboard (
		.Clock      (Clock),
		.rst_n      (rst_n),
		.runner_y   (runner_y),
		.obstacle_x (obstacle_x),
		.crashed    (crashed),
		.score      (score),
		.high_score (high_score)
	);

	score_display i_score_display (
		.score      (score),
		.high_score (high_score),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5)
	);

endmodule

`default_nettype wire

// ==== source/score_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module score_display (
	input  runner_pkg::score_t score,
	input  runner_pkg::score_t high_score,
	output runner_pkg::seg_t   hex0,
	output runner_pkg::seg_t   hex1,
	output runner_pkg::seg_t   hex2,
	output runner_pkg::seg_t   hex3,
	output runner_pkg::seg_t   hex4,
	output runner_pkg::seg_t   hex5
);
	import runner_pkg::*;

	// One decimal place of a score
	function automatic digit_t digit_of(input score_t value, input score_t weight);
		score_t place;
		place = (value / weight) % 16'd10;
		return place[3:0];
	endfunction

	function automatic seg_t to_seg(input digit_t d);
		seg_t s;
		case (d)
			4'd0: s = 7'b1000000;
			4'd1: s = 7'b1111001;
			4'd2: s = 7'b0100100;
			4'd3: s = 7'b0110000;
			4'd4: s = 7'b0011001;
			4'd5: s = 7'b0010010;
			4'd6: s = 7'b0000010;
			4'd7: s = 7'b1111000;
			4'd8: s = 7'b0000000;
			4'd9: s = 7'b0010000;
			default: s = 7'b1111111;   // Blank
		endcase
		return s;
	endfunction

	// Current run on the low three digits
	assign hex0 = to_seg(digit_of(score, 16'd1));
	assign hex1 = to_seg(digit_of(score, 16'd10));
	assign hex2 = to_seg(digit_of(score, 16'd100));

	assign hex3 = to_seg(digit_of(high_score, 16'd1));
	assign hex4 = to_seg(digit_of(high_score, 16'd10));
	assign hex5 = to_seg(digit_of(high_score, 16'd100));

endmodule

`default_nettype wire

// ==== source/scoreboard.sv ====
`timescale 1ns/1ns
`include "runner_settings.svh"
`default_nettype none

module scoreboard (
	input  logic               Clock,
	input  logic               rst_n,
	input  runner_pkg::ypos_t  runner_y,
	input  runner_pkg::xpos_t  obstacle_x,
	output logic               crashed,
	output runner_pkg::score_t score,
	output runner_pkg::score_t high_score
);
	import runner_pkg::*;

	localparam xpos_t RUNNER_COL = xpos_t'(`RUNNER_X);
	localparam ypos_t OBSTACLE_ROW = ypos_t'(`OBSTACLE_Y);
	localparam xpos_t START_X = xpos_t'(`SCREEN_W);

	xpos_t  dx;
	ypos_t  dy;
	logic   overlap;
	logic   passed;
	xpos_t  prev_x;
	logic   crashed_q;
	score_t best = '0;   // Survives rst_n

	// Box distances to the runner
	assign dx = (obstacle_x > RUNNER_COL) ? obstacle_x - RUNNER_COL
		: RUNNER_COL - obstacle_x;
	assign dy = (runner_y > OBSTACLE_ROW) ? runner_y - OBSTACLE_ROW
		: OBSTACLE_ROW - runner_y;
	assign overlap = (dx <= xpos_t'(`HIT_W)) && (dy <= ypos_t'(`HIT_H));

	// Obstacle just moved past the runner column
	assign passed = (prev_x > RUNNER_COL) && (obstacle_x <= RUNNER_COL);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			crashed <= 1'b0;
			crashed_q <= 1'b0;
			prev_x <= START_X;
			score <= '0;
		end else begin
			crashed <= crashed | overlap;
			crashed_q <= crashed;
			prev_x <= obstacle_x;
			// crashed already covers an overlap one cycle back
			if (passed && !overlap && !crashed)
				score <= score + 1'b1;
		end
	end

	// Best run is taken when a crash begins
	always_ff @(posedge Clock) begin
		if (rst_n && crashed && !crashed_q && score > best)
			best <= score;
	end

	assign high_score = best;

endmodule

`default_nettype wire

// ==== source/obstacle_track.sv ====
`timescale 1ns/1ns
`include "runner_settings.svh"
`default_nettype none

module obstacle_track (
	input  logic              Clock,
	input  logic              rst_n,
	input  logic              crashed,
	output logic              game_tick,
	output runner_pkg::xpos_t obstacle_x
);
	import runner_pkg::*;

	localparam int TICK_W = $clog2(`GAME_TICK_CYCLES);
	localparam xpos_t START_X = xpos_t'(`SCREEN_W);
	localparam xpos_t WRAP_X = xpos_t'(`SCREEN_W - `BOX_W);

	logic [TICK_W-1:0] tick_cnt;

	// Game step divider, stalls during a crash
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			game_tick <= 1'b0;
		end else if (crashed) begin
			game_tick <= 1'b0;
		end else begin
			game_tick <= (tick_cnt == TICK_W'(`GAME_TICK_CYCLES - 1));
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Scroll left one column per step
	always_ff @(posedge Clock) begin
		if (!rst_n)
			obstacle_x <= START_X;
		else if (game_tick && !crashed) begin
			if (obstacle_x <= xpos_t'(1))
				obstacle_x <= WRAP_X;   // Back in at the right edge
			else
				obstacle_x <= obstacle_x - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/jump_physics.sv ====
`timescale 1ns/1ns
`include "runner_settings.svh"
`default_nettype none

module jump_physics (
	input  logic              Clock,
	input  logic              rst_n,
	input  logic              game_tick,
	input  logic              jump_cmd,
	input  logic              duck_cmd,
	input  logic              crashed,
	output runner_pkg::ypos_t runner_y
);
	import runner_pkg::*;

	localparam vel_t LAUNCH_VEL = -vel_t'(`JUMP_FORCE);
	localparam vel_t FALL_STEP = vel_t'(`GRAVITY);
	localparam ypos_t GROUND = ypos_t'(`GROUND_Y);
	localparam logic signed [10:0] GROUND_S = 11'(`GROUND_Y);
	localparam int DUCK_W = $clog2(`DUCK_STEPS + 1);

	jump_state_t        state;
	vel_t               vel;
	vel_t               vel_next;
	logic signed [10:0] next_y;    // Row after this step, may pass ground
	logic [DUCK_W-1:0]  duck_left;
	logic               ducking;

	assign ducking = (duck_left != '0);
	assign next_y = $signed({3'b000, runner_y}) + vel;
	assign vel_next = vel + FALL_STEP;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state <= RUNNING;
			vel <= '0;
			runner_y <= GROUND;
			duck_left <= '0;
		end else if (!crashed) begin
			// Duck counts game steps
			if (duck_cmd && state == RUNNING)
				duck_left <= DUCK_W'(`DUCK_STEPS);
			else if (game_tick && ducking)
				duck_left <= duck_left - 1'b1;

			if (jump_cmd && state == RUNNING && !ducking) begin
				vel <= LAUNCH_VEL;
				state <= ASCENDING;
			end else if (game_tick && state != RUNNING) begin
				if (next_y >= GROUND_S) begin
					runner_y <= GROUND;   // Land
					vel <= '0;
					state <= RUNNING;
				end else begin
					runner_y <= next_y[7:0];
					vel <= vel_next;
					state <= vel_next[9] ? ASCENDING : DESCENDING;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/command_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module command_decoder (
	input  logic       Clock,
	input  logic       rst_n,
	input  logic [7:0] rx_byte,
	input  logic       rx_strobe,
	output logic       jump_cmd,
	output logic       duck_cmd
);

	localparam logic [7:0] CMD_JUMP = "J";
	localparam logic [7:0] CMD_DUCK = "D";

	// Idle "I" and every other byte fall through with no pulse
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			jump_cmd <= 1'b0;
			duck_cmd <= 1'b0;
		end else begin
			jump_cmd <= rx_strobe && (rx_byte == CMD_JUMP);
			duck_cmd <= rx_strobe && (rx_byte == CMD_DUCK);
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_sampler.sv ====
`timescale 1ns/1ns
`include "runner_settings.svh"
`default_nettype none

module uart_sampler (
	input  logic       Clock,
	input  logic       rst_n,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_strobe
);
	import runner_pkg::*;

	localparam int OS_DIV = `CLK_HZ / (`BAUD * 16);
	localparam int OS_W = (OS_DIV > 1) ? $clog2(OS_DIV) : 1;

	logic [OS_W-1:0] os_cnt;
	logic            os_tick;
	logic            rx_meta;
	logic            rx_sync;
	rx_state_t       state;
	logic [3:0]      sub_cnt;   // Oversample ticks left in this bit
	logic [2:0]      bit_idx;
	logic [7:0]      shift;
	logic            bit_end;

	// 16x oversampling tick
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			os_cnt <= '0;
			os_tick <= 1'b0;
		end else if (os_cnt == OS_W'(OS_DIV - 1)) begin
			os_cnt <= '0;
			os_tick <= 1'b1;
		end else begin
			os_cnt <= os_cnt + 1'b1;
			os_tick <= 1'b0;
		end
	end

	// Two-flop synchronizer, idle line is high
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	assign bit_end = os_tick && (sub_cnt == 4'd0);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state <= IDLE;
			sub_cnt <= '0;
			bit_idx <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			if (os_tick && sub_cnt != 4'd0)
				sub_cnt <= sub_cnt - 1'b1;
			case (state)
				IDLE: if (os_tick && !rx_sync) begin
					state <= START;
					sub_cnt <= 4'd7;   // Half a bit to reach mid start bit
				end
				START: if (bit_end) begin
					state <= rx_sync ? IDLE : DATA;   // Glitch returns to idle
					sub_cnt <= 4'd15;
					bit_idx <= '0;
				end
				DATA: if (bit_end) begin
					sub_cnt <= 4'd15;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= STOP;
				end
				STOP: if (bit_end) begin
					state <= IDLE;
					rx_strobe <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge Clock) begin
		if (state == DATA && bit_end)
			shift <= {rx_sync, shift[7:1]};
		if (state == STOP && bit_end)
			rx_byte <= shift;
	end

endmodule

`default_nettype wire

// ==== source/runner_pkg.sv ====
`default_nettype none

package runner_pkg;

	// Screen coordinates
	typedef logic [8:0] xpos_t;   // Column, up to 320
	typedef logic [7:0] ypos_t;   // Row

	// Vertical speed in rows per game step, negative is upward
	typedef logic signed [9:0] vel_t;

	typedef logic [15:0] score_t;

	// Display
	typedef logic [3:0] digit_t;
	typedef logic [6:0] seg_t;    // Active low, bit 0 is segment a

	// UART receiver
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} rx_state_t;

	// Runner vertical motion
	typedef enum logic [1:0] {
		RUNNING,
		ASCENDING,
		DESCENDING
	} jump_state_t;

endpackage

`default_nettype wire

// ==== source/runner_settings.svh ====
`ifndef RUNNER_SETTINGS_SVH
`define RUNNER_SETTINGS_SVH

`default_nettype none

// Clock and serial line
`define CLK_HZ 10000000
`define BAUD 312500

// Clocks per game step
`define GAME_TICK_CYCLES 64

// Screen and boxes, in pixels
`define SCREEN_W 320
`define BOX_W 32
`define HIT_W 20
`define HIT_H 30

// Fixed positions
`define RUNNER_X 52
`define GROUND_Y 109
`define OBSTACLE_Y 114

// Jump physics, per game step
`define JUMP_FORCE 10   // Rows per step upward at launch
`define GRAVITY 1
`define DUCK_STEPS 40

`default_nettype wire

`endif
